// ==== include/rv_macros.svh ====
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// ----------------------------------------
// Major opcodes, RV32I subset
// ----------------------------------------
`define OPCODE_LUI    7'b0110111
`define OPCODE_AUIPC  7'b0010111
`define OPCODE_JAL    7'b1101111
`define OPCODE_JALR   7'b1100111
`define OPCODE_LOAD   7'b0000011
`define OPCODE_STORE  7'b0100011
`define OPCODE_OPIMM  7'b0010011
`define OPCODE_OP     7'b0110011

// Load widths by funct3
`define INST_LB       3'b000
`define INST_LH       3'b001
`define INST_LW       3'b010
`define INST_LBU      3'b100
`define INST_LHU      3'b101

// ALU funct3 codes, shared by OP and OP-IMM
`define ALU_ADD       3'b000
`define ALU_SLL       3'b001
`define ALU_SLT       3'b010
`define ALU_SLTU      3'b011
`define ALU_XOR       3'b100
`define ALU_SR        3'b101
`define ALU_OR        3'b110
`define ALU_AND       3'b111

// Memory map
`define RV_RESET_PC   32'h0000_0000
`define RV_DATA_BASE  32'h0000_0400

`endif

// ==== hdl/rv_pkg.sv ====
package rv_pkg;

    // R and I formats share one layout
    // I immediate is funct7 and rs2 joined
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rType_t;

    // Store format, immediate split around rs2/rs1
    typedef struct packed {
        logic [6:0] imm11to5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm4to0;
        logic [6:0] opcode;
    } sType_t;

    // U and J formats, J bits are scrambled inside imm31to12
    typedef struct packed {
        logic [19:0] imm31to12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } uType_t;

    typedef union packed {
        logic [31:0] raw;
        rType_t      r;
        sType_t      s;
        uType_t      u;
    } instWord_u;

endpackage

// ==== hdl/RegisterFile.sv ====
`timescale 1ns/10ps

module RegisterFile (
    input  logic        clk,
    input  logic        rst,
    input  logic [4:0]  raddr1,
    input  logic [4:0]  raddr2,
    input  logic [4:0]  waddr,
    input  logic [31:0] wdata,
    input  logic        regWrite,
    output logic [31:0] rdata1,
    output logic [31:0] rdata2
);

    // x1 to x31, x0 has no storage
    logic [31:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (regWrite && (waddr != 5'd0)) begin
            regs[waddr] <= wdata;
        end
    end

    // Combinational reads, x0 forced to zero
    assign rdata1 = (raddr1 == 5'd0) ? 32'd0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? 32'd0 : regs[raddr2];

endmodule

// ==== hdl/ImmGen.sv ====
`timescale 1ns/10ps
`include "rv_macros.svh"

module ImmGen (
    input  rv_pkg::instWord_u instr,
    output logic [31:0]       imm32
);

    always_comb begin
        case (instr.r.opcode)
            // I format, imm[11:0] in the top 12 bits
            `OPCODE_JALR, `OPCODE_LOAD, `OPCODE_OPIMM:
                imm32 = {{20{instr.r.funct7[6]}}, instr.r.funct7, instr.r.rs2};
            // S format
            `OPCODE_STORE:
                imm32 = {{20{instr.s.imm11to5[6]}}, instr.s.imm11to5, instr.s.imm4to0};
            // U format, upper 20 bits
            `OPCODE_LUI, `OPCODE_AUIPC:
                imm32 = {instr.u.imm31to12, 12'd0};
            // J format: imm[20|10:1|11|19:12]
            `OPCODE_JAL:
                imm32 = {{12{instr.u.imm31to12[19]}},
                         instr.u.imm31to12[7:0],
                         instr.u.imm31to12[8],
                         instr.u.imm31to12[18:9],
                         1'b0};
            default:
                imm32 = 32'd0;
        endcase
    end

endmodule

// ==== hdl/Decoder.sv ====
`timescale 1ns/10ps
`include "rv_macros.svh"

module Decoder (
    input  logic              clk,
    input  logic              rst,
    input  logic [31:0]       aluResult,
    input  logic [31:0]       memData,
    input  logic [31:0]       pc,
    input  logic              regWrite,
    input  rv_pkg::instWord_u instr,
    output logic [31:0]       rdata1,
    output logic [31:0]       rdata2,
    output logic [31:0]       imm32,
    output logic [31:0]       wbData
);

    logic [6:0]  opcode;
    logic [4:0]  raddr1;
    logic [4:0]  raddr2;
    logic [4:0]  rd;
    logic [2:0]  funct3;
    logic [31:0] pc4;

    // ----------------------------------------
    // Field split
    // ----------------------------------------
    assign opcode = instr.r.opcode;
    assign raddr1 = instr.r.rs1;
    // Same bit slot for R and S, store data comes from here
    assign raddr2 = instr.s.rs2;
    assign rd     = instr.r.rd;
    assign funct3 = instr.r.funct3;
    assign pc4    = pc + 32'd4;

    // ----------------------------------------
    // Write-back select
    // ----------------------------------------
    always_comb begin
        if ((opcode == `OPCODE_JAL) || (opcode == `OPCODE_JALR)) begin
            wbData = pc4;
        end else if (opcode == `OPCODE_LUI) begin
            wbData = imm32;
        end else if (opcode == `OPCODE_AUIPC) begin
            wbData = pc + imm32;
        end else if (opcode == `OPCODE_LOAD) begin
            // Low lanes of the captured word only
            case (funct3)
                `INST_LB:  wbData = {{24{memData[7]}}, memData[7:0]};
                `INST_LH:  wbData = {{16{memData[15]}}, memData[15:0]};
                `INST_LW:  wbData = memData;
                `INST_LBU: wbData = {24'd0, memData[7:0]};
                `INST_LHU: wbData = {16'd0, memData[15:0]};
                default:   wbData = 32'd0;
            endcase
        end else begin
            wbData = aluResult;
        end
    end

    RegisterFile uRegisterFile (
        .clk      (clk),
        .rst      (rst),
        .raddr1   (raddr1),
        .raddr2   (raddr2),
        .waddr    (rd),
        .wdata    (wbData),
        .regWrite (regWrite),
        .rdata1   (rdata1),
        .rdata2   (rdata2)
    );

    ImmGen uImmGen (
        .instr (instr),
        .imm32 (imm32)
    );

endmodule

// ==== hdl/Alu.sv ====
`timescale 1ns/10ps
`include "rv_macros.svh"

module Alu (
    input  rv_pkg::instWord_u instr,
    input  logic [31:0]       rdata1,
    input  logic [31:0]       rdata2,
    input  logic [31:0]       imm32,
    output logic [31:0]       aluResult
);

    logic        isOp;
    logic        altOp;
    logic [31:0] opB;
    logic [4:0]  shamt;

    // Register operand for OP, immediate for OP-IMM
    assign isOp  = (instr.r.opcode == `OPCODE_OP);
    assign opB   = isOp ? rdata2 : imm32;
    // funct7[5], also imm[10] for SRAI
    assign altOp = instr.r.funct7[5];
    assign shamt = opB[4:0];

    always_comb begin
        case (instr.r.opcode)
            // Address generation
            `OPCODE_LOAD, `OPCODE_STORE, `OPCODE_JALR: begin
                aluResult = rdata1 + imm32;
            end
            `OPCODE_OP, `OPCODE_OPIMM: begin
                case (instr.r.funct3)
                    `ALU_ADD:  aluResult = (isOp && altOp) ? rdata1 - opB : rdata1 + opB;
                    `ALU_SLL:  aluResult = rdata1 << shamt;
                    `ALU_SLT:  aluResult = {31'd0, $signed(rdata1) < $signed(opB)};
                    `ALU_SLTU: aluResult = {31'd0, rdata1 < opB};
                    `ALU_XOR:  aluResult = rdata1 ^ opB;
                    `ALU_SR: begin
                        // Arithmetic shift kept apart so the sign survives
                        if (altOp) begin
                            aluResult = $signed(rdata1) >>> shamt;
                        end else begin
                            aluResult = rdata1 >> shamt;
                        end
                    end
                    `ALU_OR:   aluResult = rdata1 | opB;
                    default:   aluResult = rdata1 & opB;
                endcase
            end
            default: begin
                aluResult = 32'd0;
            end
        endcase
    end

endmodule

// ==== hdl/CoreCtrl.sv ====
`timescale 1ns/10ps
`include "rv_macros.svh"

module CoreCtrl (
    input  logic              clk,
    input  logic              rst,
    output logic [31:0]       paddr,
    output logic              pwrite,
    output logic              psel,
    output logic              penable,
    output logic [31:0]       pwdata,
    input  logic [31:0]       prdata,
    input  logic              pready,
    output rv_pkg::instWord_u instr,
    output logic [31:0]       pc,
    output logic [31:0]       memData,
    output logic              regWrite,
    input  logic [31:0]       rdata2,
    input  logic [31:0]       imm32,
    input  logic [31:0]       aluResult,
    input  logic [31:0]       wbData,
    output logic              retireValid,
    output logic [31:0]       retirePc,
    output logic [4:0]        retireRd,
    output logic [31:0]       retireData
);

    // IDLE only once, right after reset
    typedef enum logic [2:0] {
        IDLE, FETCH_SETUP, FETCH_ACCESS, EXEC, MEM_SETUP, MEM_ACCESS, WB
    } ctrlState_e;

    ctrlState_e  state;
    ctrlState_e  nextState;
    logic        isLoad;
    logic        isStore;
    logic        writesRd;
    logic        memPhase;
    logic [31:0] nextPc;

    // ----------------------------------------
    // Instruction class
    // ----------------------------------------
    always_comb begin
        isLoad   = 1'b0;
        isStore  = 1'b0;
        writesRd = 1'b0;
        case (instr.r.opcode)
            `OPCODE_LUI, `OPCODE_AUIPC, `OPCODE_JAL, `OPCODE_JALR,
            `OPCODE_OPIMM, `OPCODE_OP: begin
                writesRd = 1'b1;
            end
            `OPCODE_LOAD: begin
                // Reserved widths fall through as no-ops
                isLoad   = (instr.r.funct3 == `INST_LB)  || (instr.r.funct3 == `INST_LH) ||
                           (instr.r.funct3 == `INST_LW)  || (instr.r.funct3 == `INST_LBU) ||
                           (instr.r.funct3 == `INST_LHU);
                writesRd = isLoad;
            end
            `OPCODE_STORE: begin
                // SW only, funct3 same as LW
                isStore = (instr.s.funct3 == `INST_LW);
            end
            default: begin
            end
        endcase
    end

    // ----------------------------------------
    // State machine
    // ----------------------------------------
    always_comb begin
        nextState = state;
        case (state)
            IDLE:         nextState = FETCH_SETUP;
            FETCH_SETUP:  nextState = FETCH_ACCESS;
            FETCH_ACCESS: if (pready) nextState = EXEC;
            EXEC:         nextState = (isLoad || isStore) ? MEM_SETUP : WB;
            MEM_SETUP:    nextState = MEM_ACCESS;
            MEM_ACCESS:   if (pready) nextState = WB;
            default:      nextState = FETCH_SETUP;
        endcase
    end

    // Next PC, only taken in WB
    always_comb begin
        case (instr.r.opcode)
            `OPCODE_JAL:  nextPc = pc + imm32;
            `OPCODE_JALR: nextPc = {aluResult[31:1], 1'b0};
            default:      nextPc = pc + 32'd4;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            pc    <= `RV_RESET_PC;
        end else begin
            state <= nextState;
            if (state == WB) begin
                pc <= nextPc;
            end
        end
    end

    // Capture on the completing access cycle
    always_ff @(posedge clk) begin
        if ((state == FETCH_ACCESS) && pready) begin
            instr.raw <= prdata;
        end
        if ((state == MEM_ACCESS) && pready && !pwrite) begin
            memData <= prdata;
        end
    end

    // ----------------------------------------
    // APB requester
    // ----------------------------------------
    assign memPhase = (state == MEM_SETUP) || (state == MEM_ACCESS);
    assign psel     = (state == FETCH_SETUP) || (state == FETCH_ACCESS) || memPhase;
    assign penable  = (state == FETCH_ACCESS) || (state == MEM_ACCESS);
    assign pwrite   = memPhase && isStore;
    // Held steady by the frozen instr and register file
    assign paddr    = memPhase ? aluResult : pc;
    assign pwdata   = rdata2;

    // Write-back and retire trace
    assign regWrite    = (state == WB) && writesRd;
    assign retireValid = (state == WB);
    assign retirePc    = pc;
    assign retireRd    = writesRd ? instr.r.rd : 5'd0;
    assign retireData  = (writesRd && (instr.r.rd != 5'd0)) ? wbData : 32'd0;

endmodule

// ==== hdl/RvCore.sv ====
`timescale 1ns/10ps

module RvCore (
    input  logic        clk,
    input  logic        rst,
    output logic [31:0] paddr,
    output logic        pwrite,
    output logic        psel,
    output logic        penable,
    output logic [31:0] pwdata,
    input  logic [31:0] prdata,
    input  logic        pready,
    output logic        retireValid,
    output logic [31:0] retirePc,
    output logic [4:0]  retireRd,
    output logic [31:0] retireData
);

    // Controller to decode stage
    rv_pkg::instWord_u instr;
    logic [31:0]       pc;
    logic [31:0]       memData;
    logic              regWrite;

    // Decode stage and ALU results
    logic [31:0]       rdata1;
    logic [31:0]       rdata2;
    logic [31:0]       imm32;
    logic [31:0]       wbData;
    logic [31:0]       aluResult;

    // Port names match the nets one to one
    CoreCtrl uCoreCtrl (.*);

    Decoder uDecoder (.*);

    Alu uAlu (.*);

endmodule

// ==== tb/RvCore_checker.sv ====
`timescale 1ns/10ps

module RvCore_checker (
    input logic        clk,
    input logic        rst,
    input logic        psel,
    input logic        penable,
    input logic        pwrite,
    input logic        pready,
    input logic [31:0] paddr,
    input logic [31:0] pwdata
);

    // Failed assertions so far
    int assertFails = 0;

    // ----------------------------------------
    // APB requester protocol
    // ----------------------------------------
    penableNeedsPsel: assert property (@(posedge clk) disable iff (rst)
        penable |-> psel)
        else begin
            assertFails++;
            $error("APB penable high while psel is low");
        end

    setupThenAccess: assert property (@(posedge clk) disable iff (rst)
        (psel && !penable) |=> (psel && penable))
        else begin
            assertFails++;
            $error("APB setup phase not followed by an access phase");
        end

    // Whole request frozen through the wait states
    holdWhileWaiting: assert property (@(posedge clk) disable iff (rst)
        (penable && !pready) |=>
            (psel && $stable(paddr) && $stable(pwrite) && $stable(pwdata)))
        else begin
            assertFails++;
            $error("APB request changed while pready was low");
        end

endmodule

bind RvCore RvCore_checker i_RvCore_checker (.*);

// ==== tb/RvCoreMonitor.sv ====
`timescale 1ns/10ps
`include "rv_macros.svh"

module RvCoreMonitor (
    input  logic        clk,
    input  logic        rst,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic        pready,
    input  logic [31:0] paddr,
    input  logic [31:0] pwdata,
    input  logic        retireValid,
    input  logic [31:0] retirePc,
    input  logic [4:0]  retireRd,
    input  logic [31:0] retireData,
    output int          errorCount,
    output int          retireCount
);

    // Reference copy of the memory, filled by the testbench top
    logic [31:0] refMem [0:511];
    logic [31:0] regs [0:31];
    logic [31:0] modelPc;
    logic        firstSeen;
    // Last completed APB transfer
    logic [31:0] lastAddr;
    logic [31:0] lastWdata;
    logic        lastWrite;
    int          errors = 0;
    int          retires = 0;
    int          k;

    assign errorCount  = errors;
    assign retireCount = retires;

    task automatic compareValue(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("FAILED time=%0t signal=%s expected=%h actual=%h",
                     $time, name, expected, actual);
        end
    endtask

    // RV32I integer ops, sub and arith picked by the caller
    function automatic logic [31:0] aluModel(input logic [2:0] f3, input logic sub,
                                             input logic arith, input logic [31:0] a,
                                             input logic [31:0] b);
        case (f3)
            `ALU_ADD:  return sub ? (a - b) : (a + b);
            `ALU_SLL:  return a << b[4:0];
            `ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            `ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
            `ALU_XOR:  return a ^ b;
            `ALU_SR: begin
                if (arith) begin
                    return $signed(a) >>> b[4:0];
                end
                return a >> b[4:0];
            end
            `ALU_OR:   return a | b;
            default:   return a & b;
        endcase
    endfunction

    // ----------------------------------------
    // One instruction of the reference model
    // ----------------------------------------
    task automatic executeInstruction();
        rv_pkg::instWord_u inst;
        logic [31:0] rs1v;
        logic [31:0] rs2v;
        logic [31:0] immI;
        logic [31:0] immS;
        logic [31:0] immU;
        logic [31:0] immJ;
        logic [31:0] result;
        logic [31:0] nextPc;
        logic [31:0] addr;
        logic [31:0] word;
        logic        hasRd;
        inst.raw = refMem[modelPc[10:2]];
        rs1v   = regs[inst.r.rs1];
        rs2v   = regs[inst.s.rs2];
        immI   = {{20{inst.r.funct7[6]}}, inst.r.funct7, inst.r.rs2};
        immS   = {{20{inst.s.imm11to5[6]}}, inst.s.imm11to5, inst.s.imm4to0};
        immU   = {inst.u.imm31to12, 12'd0};
        // J immediate bits sit as imm[20|10:1|11|19:12]
        immJ   = {{12{inst.raw[31]}}, inst.raw[19:12], inst.raw[20], inst.raw[30:21], 1'b0};
        hasRd  = 1'b1;
        result = 32'd0;
        nextPc = modelPc + 32'd4;
        case (inst.r.opcode)
            `OPCODE_LUI:   result = immU;
            `OPCODE_AUIPC: result = modelPc + immU;
            `OPCODE_JAL: begin
                result = modelPc + 32'd4;
                nextPc = modelPc + immJ;
            end
            `OPCODE_JALR: begin
                result = modelPc + 32'd4;
                nextPc = (rs1v + immI) & ~32'd1;
            end
            // SUB only for OP, SRA/SRAI from bit 30 either way
            `OPCODE_OPIMM: result = aluModel(inst.r.funct3, 1'b0, inst.raw[30], rs1v, immI);
            `OPCODE_OP:    result = aluModel(inst.r.funct3, inst.raw[30], inst.raw[30],
                                             rs1v, rs2v);
            `OPCODE_LOAD: begin
                addr = rs1v + immI;
                word = refMem[addr[10:2]];
                compareValue("pwrite (load)", 32'd0, {31'd0, lastWrite});
                compareValue("paddr (load)", addr, lastAddr);
                // Data in the low lanes of the word
                case (inst.r.funct3)
                    `INST_LB:  result = {{24{word[7]}}, word[7:0]};
                    `INST_LH:  result = {{16{word[15]}}, word[15:0]};
                    `INST_LW:  result = word;
                    `INST_LBU: result = {24'd0, word[7:0]};
                    `INST_LHU: result = {16'd0, word[15:0]};
                    default:   hasRd = 1'b0;
                endcase
            end
            `OPCODE_STORE: begin
                hasRd = 1'b0;
                if (inst.s.funct3 == `INST_LW) begin
                    addr = rs1v + immS;
                    compareValue("pwrite (store)", 32'd1, {31'd0, lastWrite});
                    compareValue("paddr (store)", addr, lastAddr);
                    compareValue("pwdata", rs2v, lastWdata);
                    refMem[addr[10:2]] = rs2v;
                end
            end
            default: hasRd = 1'b0;
        endcase
        compareValue("retirePc", modelPc, retirePc);
        compareValue("retireRd", hasRd ? {27'd0, inst.r.rd} : 32'd0, {27'd0, retireRd});
        compareValue("retireData", (hasRd && (inst.r.rd != 5'd0)) ? result : 32'd0,
                     retireData);
        // x0 never written in the model
        if (hasRd && (inst.r.rd != 5'd0)) begin
            regs[inst.r.rd] = result;
        end
        modelPc = nextPc;
        retires++;
    endtask

    // Everything settled by the falling edge
    always @(negedge clk) begin
        if (rst) begin
            for (k = 0; k < 32; k++) begin
                regs[k] = 32'd0;
            end
            modelPc   = `RV_RESET_PC;
            firstSeen = 1'b0;
            lastWrite = 1'b0;
            if ((psel !== 1'b0) || (penable !== 1'b0) || (retireValid !== 1'b0)) begin
                errors++;
                $display("psel, penable or retireValid is not low during reset at %0t", $time);
            end
        end else begin
            if (psel && !firstSeen) begin
                firstSeen = 1'b1;
                compareValue("paddr (first fetch)", `RV_RESET_PC, paddr);
                if (pwrite) begin
                    errors++;
                    $display("First APB transfer after reset is a write, not a fetch");
                end
            end
            if (psel && penable && pready) begin
                lastAddr  = paddr;
                lastWrite = pwrite;
                lastWdata = pwdata;
            end
            if (retireValid) begin
                executeInstruction();
            end
        end
    end

endmodule

// ==== tb/tb_RvCore.sv ====
`timescale 1ns/10ps
`include "rv_macros.svh"

module tb_RvCore;

    logic        clk;
    logic        rst;
    logic [31:0] paddr;
    logic        pwrite;
    logic        psel;
    logic        penable;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        retireValid;
    logic [31:0] retirePc;
    logic [4:0]  retireRd;
    logic [31:0] retireData;

    // Program below RV_DATA_BASE, data region above, 2 KB in all
    logic [31:0] mem [0:511];
    int          seed;
    int          waitLeft;
    int          errorCount;
    int          retireCount;
    int          totalErrors;
    int          cycles;
    int          kind;
    int          off;
    int          i;
    logic        timedOut;
    logic [31:0] r;
    logic [31:0] r2;
    logic [31:0] imm;
    logic [6:0]  f7;
    logic [2:0]  f3;

    // ----------------------------------------
    // Instruction encoders
    // ----------------------------------------
    function automatic logic [31:0] encodeI(input logic [31:0] immv, input logic [4:0] rs1,
                                            input logic [2:0] fn3, input logic [4:0] rd,
                                            input logic [6:0] op);
        return {immv[11:0], rs1, fn3, rd, op};
    endfunction

    function automatic logic [31:0] encodeS(input logic [31:0] immv, input logic [4:0] rs2,
                                            input logic [4:0] rs1, input logic [2:0] fn3);
        return {immv[11:5], rs2, rs1, fn3, immv[4:0], `OPCODE_STORE};
    endfunction

    function automatic logic [31:0] encodeJ(input logic [31:0] immv, input logic [4:0] rd);
        return {immv[20], immv[10:1], immv[11], immv[19:12], rd, `OPCODE_JAL};
    endfunction

    function automatic logic [2:0] pickLoadWidth(input logic [2:0] sel);
        case (sel % 5)
            0:       return `INST_LB;
            1:       return `INST_LH;
            2:       return `INST_LW;
            3:       return `INST_LBU;
            default: return `INST_LHU;
        endcase
    endfunction

    always #50 clk = ~clk;

    RvCore i_RvCore (.*);

    RvCoreMonitor i_RvCoreMonitor (.*);

    // ----------------------------------------
    // APB memory responder, 0 to 3 wait cycles
    // ----------------------------------------
    always @(posedge clk) begin
        #1;
        if (psel && !penable) begin
            waitLeft = $unsigned($random(seed)) % 4;
            pready   = 1'b0;
        end else if (psel && penable) begin
            if (waitLeft == 0) begin
                // Request held until the edge that completes it
                if (pwrite) begin
                    mem[paddr[10:2]] = pwdata;
                end else begin
                    prdata = mem[paddr[10:2]];
                end
                pready = 1'b1;
            end else begin
                waitLeft = waitLeft - 1;
            end
        end else begin
            pready = 1'b0;
        end
    end

    initial begin
        clk    = 1'b0;
        rst    = 1'b1;
        prdata = 32'd0;
        pready = 1'b0;
        seed   = 97;

        // Random program, then self loops up to the data region
        for (i = 0; i < 200; i++) begin
            r    = $random(seed);
            r2   = $random(seed);
            f3   = r[17:15];
            off  = 4 * (1 + r[19:18]);
            kind = r2 % 10;
            case (kind)
                0: mem[i] = {r2[31:12], r[4:0], `OPCODE_LUI};
                1: mem[i] = {r2[31:12], r[4:0], `OPCODE_AUIPC};
                2: mem[i] = encodeJ(off, r[4:0]);
                // Base x0, so the target is absolute
                3: mem[i] = encodeI(i * 4 + off, 5'd0, 3'd0, r[4:0], `OPCODE_JALR);
                4, 5: begin
                    if (f3 == `ALU_SLL) begin
                        imm = {27'd0, r2[24:20]};
                    end else if (f3 == `ALU_SR) begin
                        imm = {21'd0, r2[25], 5'd0, r2[24:20]};
                    end else begin
                        imm = {20'd0, r2[31:20]};
                    end
                    mem[i] = encodeI(imm, r[9:5], f3, r[4:0], `OPCODE_OPIMM);
                end
                6, 7: begin
                    f7 = ((f3 == `ALU_ADD) || (f3 == `ALU_SR)) ? {1'b0, r2[25], 5'd0} : 7'd0;
                    mem[i] = {f7, r[14:10], r[9:5], f3, r[4:0], `OPCODE_OP};
                end
                // Word-aligned for every width
                8: mem[i] = encodeI(`RV_DATA_BASE + {r2[7:0], 2'b00}, 5'd0,
                                    pickLoadWidth(r2[10:8]), r[4:0], `OPCODE_LOAD);
                default: mem[i] = encodeS(`RV_DATA_BASE + {r2[7:0], 2'b00}, r[14:10],
                                          5'd0, `INST_LW);
            endcase
        end
        for (i = 200; i < 256; i++) begin
            mem[i] = encodeJ(32'd0, 5'd0);
        end
        for (i = 256; i < 512; i++) begin
            mem[i] = $random(seed);
        end
        for (i = 0; i < 512; i++) begin
            i_RvCoreMonitor.refMem[i] = mem[i];
        end

        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;

        cycles = 0;
        while ((retireCount < 250) && (cycles < 20000)) begin
            @(posedge clk);
            cycles++;
        end
        timedOut = (retireCount < 250);
        if (timedOut) begin
            $display("Timeout after %0d cycles with only %0d instructions retired",
                     cycles, retireCount);
        end

        totalErrors = errorCount + i_RvCore.i_RvCore_checker.assertFails + (timedOut ? 1 : 0);
        $display("Errors: %0d, assertion failures: %0d, retired: %0d",
                 errorCount, i_RvCore.i_RvCore_checker.assertFails, retireCount);
        if (totalErrors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+include
hdl/rv_pkg.sv
hdl/RegisterFile.sv
hdl/ImmGen.sv
hdl/Decoder.sv
hdl/Alu.sv
hdl/CoreCtrl.sv
hdl/RvCore.sv
tb/RvCore_checker.sv
tb/RvCoreMonitor.sv
tb/tb_RvCore.sv
